// ==== design/cache_pkg.sv ====
package cache_pkg;

    // geometry
    localparam int WORD_W      = 32;   // data and address width
    localparam int CACHE_BYTES = 128;  // total capacity
    localparam int BLOCK_WORDS = 2;    // words per line
    localparam int N_WAYS      = 2;    // two-way set associative

    // derived widths
    localparam int N_SETS  = CACHE_BYTES / (BLOCK_WORDS * N_WAYS * (WORD_W / 8));
    localparam int SET_W   = $clog2(N_SETS);
    localparam int BLOCK_W = $clog2(BLOCK_WORDS);
    localparam int TAG_W   = WORD_W - SET_W - BLOCK_W - 2;

    // controller state codes
    localparam int ST_W              = 3;
    localparam logic [ST_W-1:0] ST_IDLE   = 3'd0;
    localparam logic [ST_W-1:0] ST_WB     = 3'd1;  // dirty victim out
    localparam logic [ST_W-1:0] ST_FETCH  = 3'd2;  // line fill
    localparam logic [ST_W-1:0] ST_FL_SET = 3'd3;  // step to next set
    localparam logic [ST_W-1:0] ST_FL_WAY = 3'd4;  // look at one way
    localparam logic [ST_W-1:0] ST_FL_WR  = 3'd5;  // write the dirty way out

    // one address word, read flat or split into cache fields
    typedef union packed {
        logic [WORD_W-1:0] word;
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [SET_W-1:0]   set;
            logic [BLOCK_W-1:0] block;
            logic [1:0]         byte_off;  // always zero on the memory side
        } fields;
    } cache_addr_t;

endpackage

// ==== design/cache_store.sv ====
module cache_store
    import cache_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    input  cache_addr_t           addr,
    input  logic [BLOCK_W-1:0]    word_idx,
    input  logic [WORD_W-1:0]     wdata,
    input  logic [WORD_W/8-1:0]   byte_en,
    // qualified hits from the controller
    input  logic                  wr_hit,
    input  logic                  rd_hit,
    // line fill
    input  logic                  fill_we,
    input  logic [WORD_W-1:0]     fill_data,
    input  logic                  fill_commit,
    // victim write-back done
    input  logic                  wb_clean,
    // flush scan
    input  logic [SET_W-1:0]      scan_set,
    input  logic                  scan_way,
    input  logic                  scan_clean,
    output logic                  hit,
    output logic [WORD_W-1:0]     rdata,
    output logic                  victim_dirty,
    output logic [TAG_W-1:0]      victim_tag,
    output logic [WORD_W-1:0]     line_word,
    output logic                  scan_dirty,
    output logic [TAG_W-1:0]      scan_tag,
    output logic [WORD_W-1:0]     scan_word
);

    // arrays
    logic [TAG_W-1:0]  tags [N_SETS][N_WAYS];
    logic [WORD_W-1:0] data [N_SETS][N_WAYS][BLOCK_WORDS];
    logic [N_SETS-1:0][N_WAYS-1:0] valid;
    logic [N_SETS-1:0][N_WAYS-1:0] dirty;
    logic [N_SETS-1:0]             lru;  // way touched last, per set

    // request fields
    logic [TAG_W-1:0]   a_tag;
    logic [SET_W-1:0]   a_set;
    logic [BLOCK_W-1:0] a_blk;

    logic [N_WAYS-1:0] way_hit;
    logic              hit_way;
    logic              victim_way;

    assign a_tag = addr.fields.tag;
    assign a_set = addr.fields.set;
    assign a_blk = addr.fields.block;

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < N_WAYS; w++) begin
            way_hit[w] = valid[a_set][w] && (tags[a_set][w] == a_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];  // way 0 when no hit
    assign rdata   = data[a_set][hit_way][a_blk];

    // replace the way not used last
    assign victim_way   = ~lru[a_set];
    assign victim_dirty = valid[a_set][victim_way] && dirty[a_set][victim_way];
    assign victim_tag   = tags[a_set][victim_way];
    assign line_word    = data[a_set][victim_way][word_idx];

    // flush scan port
    assign scan_dirty = valid[scan_set][scan_way] && dirty[scan_set][scan_way];
    assign scan_tag   = tags[scan_set][scan_way];
    assign scan_word  = data[scan_set][scan_way][word_idx];

    // line status and lru
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (rd_hit || wr_hit) begin
                lru[a_set] <= hit_way;
            end
            if (wr_hit) begin
                dirty[a_set][hit_way] <= 1'b1;  // line now differs from memory
            end
            if (wb_clean) begin
                dirty[a_set][victim_way] <= 1'b0;
            end
            if (fill_commit) begin
                valid[a_set][victim_way] <= 1'b1;
                dirty[a_set][victim_way] <= 1'b0;
            end
            if (scan_clean) begin
                dirty[scan_set][scan_way] <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge CLK) begin
        if (wr_hit) begin
            // merge only the enabled bytes
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (byte_en[b]) begin
                    data[a_set][hit_way][a_blk][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (fill_we) begin
            data[a_set][victim_way][word_idx] <= fill_data;  // one fetched word
        end
        if (fill_commit) begin
            tags[a_set][victim_way] <= a_tag;
        end
    end

    // fill always lands in the victim, so a tag can sit in one way only
    assert property (@(posedge CLK) disable iff (!nRST) $onehot0(way_hit))
        else $error("both ways hit in set %0d", a_set);

endmodule

// ==== design/cache_ctrl.sv ====
module cache_ctrl
    import cache_pkg::*;
(
    input  logic                CLK,
    input  logic                nRST,
    input  logic                ren,
    input  logic                wen,
    input  cache_addr_t         addr,
    input  logic                flush,
    input  logic                hit,
    input  logic                victim_dirty,
    input  logic [TAG_W-1:0]    victim_tag,
    input  logic [WORD_W-1:0]   line_word,
    input  logic                scan_dirty,
    input  logic [TAG_W-1:0]    scan_tag,
    input  logic [WORD_W-1:0]   scan_word,
    input  logic                mem_busy,
    output logic                busy,
    output logic                flush_done,
    output logic                rd_hit,
    output logic                wr_hit,
    output logic [BLOCK_W-1:0]  word_idx,
    output logic                fill_we,
    output logic                fill_commit,
    output logic                wb_clean,
    output logic [SET_W-1:0]    scan_set,
    output logic                scan_way,
    output logic                scan_clean,
    output logic                mem_ren,
    output logic                mem_wen,
    output logic [WORD_W-1:0]   mem_addr,
    output logic [WORD_W-1:0]   mem_wdata
);

    logic [ST_W-1:0]    state, next_state;
    logic [BLOCK_W-1:0] word_cnt, next_word;
    logic               way_cnt, next_way;
    logic [SET_W-1:0]   set_cnt, next_set;
    logic               last_word, last_way, last_set;
    cache_addr_t        mem_a;

    assign last_word = (word_cnt == BLOCK_W'(BLOCK_WORDS - 1));
    assign last_way  = (way_cnt == 1'(N_WAYS - 1));
    assign last_set  = (set_cnt == SET_W'(N_SETS - 1));

    assign word_idx = word_cnt;  // shared by write-back, fill and scan
    assign scan_set = set_cnt;
    assign scan_way = way_cnt;
    assign mem_addr = mem_a.word;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
            way_cnt  <= 1'b0;
            set_cnt  <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word;
            way_cnt  <= next_way;
            set_cnt  <= next_set;
        end
    end

    always_comb begin
        next_state  = state;
        next_word   = word_cnt;
        next_way    = way_cnt;
        next_set    = set_cnt;
        busy        = 1'b1;  // low only on an idle hit
        flush_done  = 1'b0;
        rd_hit      = 1'b0;
        wr_hit      = 1'b0;
        fill_we     = 1'b0;
        fill_commit = 1'b0;
        wb_clean    = 1'b0;
        scan_clean  = 1'b0;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_a.word  = addr.word;
        mem_wdata   = line_word;

        case (state)
            ST_IDLE: begin
                if (ren || wen) begin
                    if (hit) begin
                        busy   = 1'b0;
                        rd_hit = ren;
                        wr_hit = wen;
                    end else if (victim_dirty) begin
                        next_state = ST_WB;  // victim out first
                    end else begin
                        next_state = ST_FETCH;
                    end
                end else if (flush) begin
                    next_set   = '0;
                    next_way   = 1'b0;
                    next_state = ST_FL_WAY;
                end
            end
            ST_WB: begin
                mem_wen    = 1'b1;
                mem_a.word = {victim_tag, addr.fields.set, word_cnt, 2'b00};
                mem_wdata  = line_word;
                if (!mem_busy) begin
                    if (last_word) begin
                        wb_clean   = 1'b1;
                        next_word  = '0;
                        next_state = ST_FETCH;
                    end else begin
                        next_word = word_cnt + 1'b1;
                    end
                end
            end
            ST_FETCH: begin
                mem_ren    = 1'b1;
                mem_a.word = {addr.fields.tag, addr.fields.set, word_cnt, 2'b00};
                if (!mem_busy) begin
                    fill_we = 1'b1;  // word is on mem_rdata now
                    if (last_word) begin
                        fill_commit = 1'b1;
                        next_word   = '0;
                        next_state  = ST_IDLE;  // request hits next cycle
                    end else begin
                        next_word = word_cnt + 1'b1;
                    end
                end
            end
            ST_FL_WAY: begin
                if (scan_dirty) begin
                    next_word  = '0;
                    next_state = ST_FL_WR;
                end else if (last_way) begin
                    next_state = ST_FL_SET;
                end else begin
                    next_way = way_cnt + 1'b1;
                end
            end
            ST_FL_WR: begin
                mem_wen    = 1'b1;
                mem_a.word = {scan_tag, set_cnt, word_cnt, 2'b00};
                mem_wdata  = scan_word;
                if (!mem_busy) begin
                    if (last_word) begin
                        scan_clean = 1'b1;
                        next_word  = '0;
                        next_state = ST_FL_WAY;  // now clean, so it moves on
                    end else begin
                        next_word = word_cnt + 1'b1;
                    end
                end
            end
            ST_FL_SET: begin
                next_way = 1'b0;
                if (last_set) begin
                    flush_done = 1'b1;
                    next_set   = '0;
                    next_state = ST_IDLE;
                end else begin
                    next_set   = set_cnt + 1'b1;
                    next_state = ST_FL_WAY;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    assert property (@(posedge CLK) disable iff (!nRST) !(ren && wen))
        else $error("ren and wen raised together");

    // done only after the last way of the last set was looked at
    assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |-> ($past(state) == ST_FL_WAY) && !$past(scan_dirty))
        else $error("flush_done outside flush sequence");

endmodule

// ==== design/l1_cache.sv ====
module l1_cache
    import cache_pkg::*;
(
    input  logic                  CLK,
    input  logic                  nRST,
    // processor bus
    input  logic                  ren,
    input  logic                  wen,
    input  cache_addr_t           addr,
    input  logic [WORD_W-1:0]     wdata,
    input  logic [WORD_W/8-1:0]   byte_en,
    output logic [WORD_W-1:0]     rdata,
    output logic                  busy,
    // flush command
    input  logic                  flush,
    output logic                  flush_done,
    // memory bus
    output logic                  mem_ren,
    output logic                  mem_wen,
    output logic [WORD_W-1:0]     mem_addr,
    output logic [WORD_W-1:0]     mem_wdata,
    input  logic                  mem_busy,
    input  logic [WORD_W-1:0]     mem_rdata
);

    // store <-> controller
    logic               hit, rd_hit, wr_hit;
    logic [BLOCK_W-1:0] word_idx;
    logic               fill_we, fill_commit, wb_clean;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [WORD_W-1:0]  line_word;
    logic [SET_W-1:0]   scan_set;
    logic               scan_way, scan_clean, scan_dirty;
    logic [TAG_W-1:0]   scan_tag;
    logic [WORD_W-1:0]  scan_word;

    cache_store u_store (
        .CLK, .nRST,
        .addr, .word_idx, .wdata, .byte_en,
        .wr_hit, .rd_hit,
        .fill_we, .fill_data(mem_rdata), .fill_commit,  // fill straight off the bus
        .wb_clean,
        .scan_set, .scan_way, .scan_clean,
        .hit, .rdata,
        .victim_dirty, .victim_tag, .line_word,
        .scan_dirty, .scan_tag, .scan_word
    );

    cache_ctrl u_ctrl (
        .CLK, .nRST,
        .ren, .wen, .addr, .flush,
        .hit, .victim_dirty, .victim_tag, .line_word,
        .scan_dirty, .scan_tag, .scan_word,
        .mem_busy,
        .busy, .flush_done,
        .rd_hit, .wr_hit, .word_idx,
        .fill_we, .fill_commit, .wb_clean,
        .scan_set, .scan_way, .scan_clean,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;  // 4 ns period
    end

    initial begin
        nRST = 1'b0;
        repeat (8) @(posedge CLK);  // 8 cycles in reset
        #1 nRST = 1'b1;  // released off the edge
    end
endmodule

// ==== test/mem_model.sv ====
module mem_model
    import cache_pkg::*;
#(
    parameter logic [31:0] INIT_KEY = 32'h0,
    parameter logic [31:0] SEED     = 32'h1
) (
    input  logic              CLK,
    input  logic              mem_ren,
    input  logic              mem_wen,
    input  logic [WORD_W-1:0] mem_addr,
    input  logic [WORD_W-1:0] mem_wdata,
    output logic              mem_busy,
    output logic [WORD_W-1:0] mem_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [WORD_W-1:0] mem [1024];  // 4 KB of words
    integer busy_seed = SEED;
    int     wait_cnt  = 0;  // cycles left before the current word is taken

    initial begin
        mem_busy = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = ((32'(i) << 2) * 32'h9E37_79B1) ^ INIT_KEY;  // whole byte address
        end
    end

    assign mem_rdata = mem[mem_addr[11:2]];  // stable while the read is held

    always @(posedge CLK) begin
        if ((mem_ren || mem_wen) && wait_cnt == 0) begin
            if (mem_wen) begin
                mem[mem_addr[11:2]] <= mem_wdata;
            end
            wait_cnt = $random(busy_seed) & 3;  // next word waits 0..3 cycles
        end else if ((mem_ren || mem_wen) && wait_cnt > 0) begin
            wait_cnt = wait_cnt - 1;
        end
        #1 mem_busy = (wait_cnt != 0);
    end
endmodule

// ==== test/tb_l1_cache.sv ====
module tb_l1_cache
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED     = 32'h63705cc7;
    localparam logic [31:0] INIT_KEY = 32'hA5C3_0F17;
    localparam int MEM_WORDS     = 1024;
    localparam int REQ_TIMEOUT   = 100;
    localparam int FLUSH_TIMEOUT = 2000;
    localparam int RAND_OPS      = 400;
    localparam logic [3:0] BE_LIST [8] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                           4'b0110, 4'b1001, 4'b1111, 4'b0000};

    logic                CLK, nRST;
    logic                ren, wen, flush, busy, flush_done;
    cache_addr_t         addr;
    logic [WORD_W-1:0]   wdata, rdata;
    logic [WORD_W/8-1:0] byte_en;
    logic                mem_ren, mem_wen, mem_busy;
    logic [WORD_W-1:0]   mem_addr, mem_wdata, mem_rdata;

    logic [WORD_W-1:0] ref_mem [MEM_WORDS];  // flat reference image
    logic [WORD_W-1:0] fetch_log [$];        // line fetches seen on the memory bus
    integer seed = SEED;
    int     reads_checked = 0;
    int     wb_words = 0;  // memory writes completed

    tb_clock u_clock (.CLK, .nRST);

    l1_cache i_l1_cache (
        .CLK, .nRST, .ren, .wen, .addr, .wdata, .byte_en, .rdata, .busy,
        .flush, .flush_done,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_busy, .mem_rdata
    );

    mem_model #(.INIT_KEY(INIT_KEY), .SEED(SEED)) u_mem (
        .CLK, .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_busy, .mem_rdata
    );

    function automatic logic [WORD_W-1:0] init_word(input logic [WORD_W-1:0] byte_addr);
        return (byte_addr * 32'h9E37_79B1) ^ INIT_KEY;
    endfunction

    function automatic logic [WORD_W-1:0] merge_bytes(input logic [WORD_W-1:0] old_w,
            input logic [WORD_W-1:0] new_w, input logic [3:0] be);
        logic [WORD_W-1:0] m;
        m = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) m[8*b +: 8] = new_w[8*b +: 8];  // enabled lanes only
        end
        return m;
    endfunction

    // expected read data straight from the reference image
    function automatic logic [WORD_W-1:0] expected_word(input cache_addr_t a);
        return ref_mem[a.word[11:2]];
    endfunction

    function automatic cache_addr_t make_addr(input int tag, input int set, input int blk);
        cache_addr_t a;
        a.word        = '0;
        a.fields.tag   = TAG_W'(tag);
        a.fields.set   = SET_W'(set);
        a.fields.block = BLOCK_W'(blk);
        return a;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic compare_rdata(input cache_addr_t a, input logic [WORD_W-1:0] exp, got);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0d ns rdata addr %h expected %h got %h",
                               $time, a.word, exp, got));
        end
    endtask

    task automatic compare_mem(input cache_addr_t a, input logic [WORD_W-1:0] exp, got);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0d ns mem word addr %h expected %h got %h",
                               $time, a.word, exp, got));
        end
    endtask

    // returns on the edge that completes the request
    task automatic wait_idle(input string what);
        int cycles;
        bit done;
        cycles = 0;
        do begin
            @(posedge CLK);
            done = !busy;
            cycles++;
        end while (!done && cycles < REQ_TIMEOUT);
        if (!done) fail_run($sformatf("timeout: busy never went low on a %s", what));
    endtask

    task automatic do_read(input cache_addr_t a);
        addr = a;
        ren  = 1'b1;
        wait_idle("read");
        #1;
        ren = 1'b0;
    endtask

    task automatic do_write(input cache_addr_t a, input logic [WORD_W-1:0] d,
            input logic [3:0] be);
        addr    = a;
        wdata   = d;
        byte_en = be;
        wen     = 1'b1;
        wait_idle("write");
        #1;
        wen = 1'b0;
    endtask

    task automatic run_flush();
        int cycles;
        bit done;
        cycles = 0;
        flush  = 1'b1;
        do begin
            @(posedge CLK);
            done = flush_done;
            cycles++;
        end while (!done && cycles < FLUSH_TIMEOUT);
        if (!done) fail_run("timeout: flush_done never came after raising flush");
        #1;
        flush = 1'b0;
    endtask

    // reference update and read compare on every completed transfer
    always @(posedge CLK) begin
        if (nRST && !busy && wen) begin
            ref_mem[addr.word[11:2]] = merge_bytes(ref_mem[addr.word[11:2]], wdata, byte_en);
        end
        if (nRST && !busy && ren) begin
            compare_rdata(addr, expected_word(addr), rdata);
            reads_checked++;
        end
        if (nRST && mem_ren && !mem_busy) fetch_log.push_back(mem_addr);  // fetch words
        if (nRST && mem_wen && !mem_busy) wb_words++;
    end

    initial begin
        cache_addr_t a;
        cache_addr_t a_b;
        int cycles;
        ren     = 1'b0;
        wen     = 1'b0;
        flush   = 1'b0;
        addr    = '0;
        wdata   = '0;
        byte_en = '0;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = init_word(32'(i) << 2);

        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
        end while (!nRST && cycles < 20);
        if (!nRST) fail_run("reset was never released");
        #1;

        // untouched lines, word 0 misses and word 1 hits
        for (int s = 0; s < N_SETS; s++) begin
            do_read(make_addr(2, s, 0));
            do_read(make_addr(2, s, 1));
        end

        // byte enable merge, write then read back
        for (int i = 0; i < 8; i++) begin
            a = make_addr(3, i, i & 1);
            do_write(a, $random(seed), BE_LIST[i]);
            do_read(a);
        end

        // three dirty tags into set 6
        for (int t = 10; t < 13; t++) do_write(make_addr(t, 6, 0), $random(seed), 4'hF);
        for (int t = 10; t < 13; t++) begin
            do_read(make_addr(t, 6, 0));
            do_read(make_addr(t, 6, 1));
        end

        // lru in set 5: A B A, then C must replace B
        do_read(make_addr(20, 5, 0));
        do_read(make_addr(21, 5, 0));
        do_read(make_addr(20, 5, 0));
        do_read(make_addr(22, 5, 0));
        fetch_log.delete();
        do_read(make_addr(20, 5, 0));
        if (fetch_log.size() != 0) fail_run("line A was fetched again though it was used last");
        a_b = make_addr(21, 5, 0);
        do_read(a_b);
        if (fetch_log.size() == 0 || fetch_log[0] != a_b.word) begin
            fail_run("line B was not refetched, so it was not the evicted way");
        end

        // random mix over all sets, few tags so hits and evictions both happen
        for (int n = 0; n < RAND_OPS; n++) begin
            a = make_addr($random(seed) & 3, $random(seed) & 7, $random(seed) & 1);
            if ($random(seed) & 1) begin
                do_write(a, $random(seed), 4'($random(seed)));
            end else begin
                do_read(a);
            end
        end

        // flush, then memory must match the reference everywhere
        run_flush();
        for (int i = 0; i < MEM_WORDS; i++) begin
            a.word = 32'(i) << 2;
            compare_mem(a, ref_mem[i], u_mem.mem[i]);
        end

        // every line is clean now, so a miss per set writes nothing back
        wb_words = 0;
        for (int s = 0; s < N_SETS; s++) do_read(make_addr(30, s, 0));
        if (wb_words != 0) fail_run("a dirty line was still written back after the flush");

        $display("%0d reads checked", reads_checked);
        $display("Verification passed");
        $finish;
    end
endmodule

// ==== verilog.f ====
design/cache_pkg.sv
design/cache_store.sv
design/cache_ctrl.sv
design/l1_cache.sv
test/tb_clock.sv
test/mem_model.sv
test/tb_l1_cache.sv
